/* verilog/axi_consts.svh */
`ifndef AXI_CONSTS_SVH
`define AXI_CONSTS_SVH

// AR channel field widths
`define AXI_ID_BITS    4
`define AXI_TAG_BITS   4
`define AXI_IDS_BITS   8  // Tag followed by master id
`define AXI_ADDR_BITS  32
`define AXI_LEN_BITS   4
`define AXI_SIZE_BITS  3
`define AXI_BURST_BITS 2

// Address map, both bounds inclusive
`define S0_BASE 32'h0000_0000
`define S0_LAST 32'h0000_FFFF
`define S1_BASE 32'h0001_0000
`define S1_LAST 32'h0001_FFFF

`endif

/* verilog/axi_pkg.sv */
`include "axi_consts.svh"

package axi_pkg;

  typedef logic [`AXI_ID_BITS-1:0]    axi_id_t;
  typedef logic [`AXI_IDS_BITS-1:0]   axi_ids_t;  // Slave side id
  typedef logic [`AXI_ADDR_BITS-1:0]  axi_addr_t;
  typedef logic [`AXI_LEN_BITS-1:0]   axi_len_t;
  typedef logic [`AXI_SIZE_BITS-1:0]  axi_size_t;
  typedef logic [`AXI_BURST_BITS-1:0] axi_burst_t;

  // Grant lock of the shared path
  typedef enum logic [1:0] {
    LOCK_FREE,
    LOCK_M0,
    LOCK_M1
  } ar_lock_t;

  typedef enum logic [1:0] {
    SLAVE_0,
    SLAVE_1,
    SLAVE_DEFAULT
  } slave_sel_t;

  // Tags put in front of the id so responses find their way back
  localparam logic [`AXI_TAG_BITS-1:0] MASTER_0_TAG = 4'h1;
  localparam logic [`AXI_TAG_BITS-1:0] MASTER_1_TAG = 4'h2;

  function automatic slave_sel_t addr_decode(input axi_addr_t addr);
    if (addr >= `S0_BASE && addr <= `S0_LAST) begin
      return SLAVE_0;
    end
    if (addr >= `S1_BASE && addr <= `S1_LAST) begin
      return SLAVE_1;
    end
    return SLAVE_DEFAULT;  // Unmapped space
  endfunction

endpackage

/* verilog/ar_chan_if.sv */
`timescale 1ns/100ps

// One AR request path, granted master towards the decoder
interface ar_chan_if
  import axi_pkg::*;
();

  axi_ids_t   id;
  axi_addr_t  addr;
  axi_len_t   len;
  axi_size_t  size;
  axi_burst_t burst;
  logic       valid;
  logic       ready;

  modport src (
    output id,
    output addr,
    output len,
    output size,
    output burst,
    output valid,
    input  ready
  );

  modport dst (
    input  id,
    input  addr,
    input  len,
    input  size,
    input  burst,
    input  valid,
    output ready
  );

endinterface

/* verilog/ar_arbiter.sv */
`timescale 1ns/100ps

module ar_arbiter
  import axi_pkg::*;
(
  input  logic       clk,
  input  logic       rstn,
  // Master 0
  input  axi_id_t    m0_id,
  input  axi_addr_t  m0_addr,
  input  axi_len_t   m0_len,
  input  axi_size_t  m0_size,
  input  axi_burst_t m0_burst,
  input  logic       m0_valid,
  output logic       m0_ready,
  // Master 1
  input  axi_id_t    m1_id,
  input  axi_addr_t  m1_addr,
  input  axi_len_t   m1_len,
  input  axi_size_t  m1_size,
  input  axi_burst_t m1_burst,
  input  logic       m1_valid,
  output logic       m1_ready,
  ar_chan_if.src     out
);

  ar_lock_t lock;
  ar_lock_t lock_next;
  logic     gnt_m0;
  logic     gnt_m1;
  logic     done;

  assign done = out.valid && out.ready;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      lock <= LOCK_FREE;
    end else begin
      lock <= lock_next;
    end
  end

  // Grant by lock, else fixed priority to m0
  always_comb begin
    gnt_m0 = 1'b0;
    gnt_m1 = 1'b0;
    case (lock)
      LOCK_M0: gnt_m0 = 1'b1;
      LOCK_M1: gnt_m1 = 1'b1;
      default: begin
        gnt_m0 = m0_valid;
        gnt_m1 = !m0_valid && m1_valid;
      end
    endcase
  end

  always_comb begin
    lock_next = lock;
    case (lock)
      LOCK_M0: begin
        if (done) begin
          lock_next = m1_valid ? LOCK_M1 : LOCK_FREE;  // Hand over if m1 waits
        end
      end
      LOCK_M1: begin
        if (done) begin
          lock_next = m0_valid ? LOCK_M0 : LOCK_FREE;
        end
      end
      default: begin
        if (gnt_m0 && !out.ready) begin
          lock_next = LOCK_M0;  // Stalled, hold the grant
        end else if (gnt_m1 && !out.ready) begin
          lock_next = LOCK_M1;
        end else begin
          lock_next = LOCK_FREE;
        end
      end
    endcase
  end

  // Request mux, zero when nobody is granted
  always_comb begin
    out.id    = '0;
    out.addr  = '0;
    out.len   = '0;
    out.size  = '0;
    out.burst = '0;
    out.valid = 1'b0;
    if (gnt_m0) begin
      out.id    = {MASTER_0_TAG, m0_id};
      out.addr  = m0_addr;
      out.len   = m0_len;
      out.size  = m0_size;
      out.burst = m0_burst;
      out.valid = m0_valid;
    end else if (gnt_m1) begin
      out.id    = {MASTER_1_TAG, m1_id};
      out.addr  = m1_addr;
      out.len   = m1_len;
      out.size  = m1_size;
      out.burst = m1_burst;
      out.valid = m1_valid;
    end
  end

  assign m0_ready = gnt_m0 && out.ready;
  assign m1_ready = gnt_m1 && out.ready;

endmodule

/* verilog/ar_decoder.sv */
`timescale 1ns/100ps

module ar_decoder
  import axi_pkg::*;
(
  ar_chan_if.dst     in,
  // Slave 0
  output axi_ids_t   s0_id,
  output axi_addr_t  s0_addr,
  output axi_len_t   s0_len,
  output axi_size_t  s0_size,
  output axi_burst_t s0_burst,
  output logic       s0_valid,
  input  logic       s0_ready,
  // Slave 1
  output axi_ids_t   s1_id,
  output axi_addr_t  s1_addr,
  output axi_len_t   s1_len,
  output axi_size_t  s1_size,
  output axi_burst_t s1_burst,
  output logic       s1_valid,
  input  logic       s1_ready,
  // Default slave
  output axi_ids_t   s2_id,
  output axi_addr_t  s2_addr,
  output axi_len_t   s2_len,
  output axi_size_t  s2_size,
  output axi_burst_t s2_burst,
  output logic       s2_valid,
  input  logic       s2_ready
);

  slave_sel_t sel;

  assign sel = addr_decode(in.addr);

  always_comb begin
    {s0_id, s0_addr, s0_len, s0_size, s0_burst, s0_valid} = '0;
    {s1_id, s1_addr, s1_len, s1_size, s1_burst, s1_valid} = '0;
    {s2_id, s2_addr, s2_len, s2_size, s2_burst, s2_valid} = '0;
    in.ready = 1'b0;
    case (sel)
      SLAVE_0: begin
        s0_id    = in.id;
        s0_addr  = in.addr;
        s0_len   = in.len;
        s0_size  = in.size;
        s0_burst = in.burst;
        s0_valid = in.valid;
        in.ready = s0_ready;
      end
      SLAVE_1: begin
        s1_id    = in.id;
        s1_addr  = in.addr;
        s1_len   = in.len;
        s1_size  = in.size;
        s1_burst = in.burst;
        s1_valid = in.valid;
        in.ready = s1_ready;
      end
      default: begin  // Anything unmapped
        s2_id    = in.id;
        s2_addr  = in.addr;
        s2_len   = in.len;
        s2_size  = in.size;
        s2_burst = in.burst;
        s2_valid = in.valid;
        in.ready = s2_ready;
      end
    endcase
  end

endmodule

/* verilog/ar_crossbar.sv */
`timescale 1ns/100ps

module ar_crossbar
  import axi_pkg::*;
(
  input  logic       clk,
  input  logic       rstn,
  // Master 0
  input  axi_id_t    m0_id,
  input  axi_addr_t  m0_addr,
  input  axi_len_t   m0_len,
  input  axi_size_t  m0_size,
  input  axi_burst_t m0_burst,
  input  logic       m0_valid,
  output logic       m0_ready,
  // Master 1
  input  axi_id_t    m1_id,
  input  axi_addr_t  m1_addr,
  input  axi_len_t   m1_len,
  input  axi_size_t  m1_size,
  input  axi_burst_t m1_burst,
  input  logic       m1_valid,
  output logic       m1_ready,
  // Slave 0
  output axi_ids_t   s0_id,
  output axi_addr_t  s0_addr,
  output axi_len_t   s0_len,
  output axi_size_t  s0_size,
  output axi_burst_t s0_burst,
  output logic       s0_valid,
  input  logic       s0_ready,
  // Slave 1
  output axi_ids_t   s1_id,
  output axi_addr_t  s1_addr,
  output axi_len_t   s1_len,
  output axi_size_t  s1_size,
  output axi_burst_t s1_burst,
  output logic       s1_valid,
  input  logic       s1_ready,
  // Default slave
  output axi_ids_t   s2_id,
  output axi_addr_t  s2_addr,
  output axi_len_t   s2_len,
  output axi_size_t  s2_size,
  output axi_burst_t s2_burst,
  output logic       s2_valid,
  input  logic       s2_ready
);

  ar_chan_if ar_bus ();  // Granted request

  ar_arbiter u_arbiter (
    .clk      (clk),
    .rstn     (rstn),
    .m0_id    (m0_id),
    .m0_addr  (m0_addr),
    .m0_len   (m0_len),
    .m0_size  (m0_size),
    .m0_burst (m0_burst),
    .m0_valid (m0_valid),
    .m0_ready (m0_ready),
    .m1_id    (m1_id),
    .m1_addr  (m1_addr),
    .m1_len   (m1_len),
    .m1_size  (m1_size),
    .m1_burst (m1_burst),
    .m1_valid (m1_valid),
    .m1_ready (m1_ready),
    .out      (ar_bus.src)
  );

  ar_decoder u_decoder (
    .in       (ar_bus.dst),
    .s0_id    (s0_id),
    .s0_addr  (s0_addr),
    .s0_len   (s0_len),
    .s0_size  (s0_size),
    .s0_burst (s0_burst),
    .s0_valid (s0_valid),
    .s0_ready (s0_ready),
    .s1_id    (s1_id),
    .s1_addr  (s1_addr),
    .s1_len   (s1_len),
    .s1_size  (s1_size),
    .s1_burst (s1_burst),
    .s1_valid (s1_valid),
    .s1_ready (s1_ready),
    .s2_id    (s2_id),
    .s2_addr  (s2_addr),
    .s2_len   (s2_len),
    .s2_size  (s2_size),
    .s2_burst (s2_burst),
    .s2_valid (s2_valid),
    .s2_ready (s2_ready)
  );

endmodule

/* verif/ar_crossbar_tb.sv */
`timescale 1ns/100ps

module ar_crossbar_tb
  import axi_pkg::*;
();

  localparam int EDGE_TIMEOUT  = 8;   // Poll steps of 1 ns, two clock periods
  localparam int RESET_TIMEOUT = 40;

  logic       clk;
  logic       rstn;
  axi_id_t    m0_id;
  axi_addr_t  m0_addr;
  axi_len_t   m0_len;
  axi_size_t  m0_size;
  axi_burst_t m0_burst;
  logic       m0_valid;
  logic       m0_ready;
  axi_id_t    m1_id;
  axi_addr_t  m1_addr;
  axi_len_t   m1_len;
  axi_size_t  m1_size;
  axi_burst_t m1_burst;
  logic       m1_valid;
  logic       m1_ready;
  axi_ids_t   s0_id, s1_id, s2_id;
  axi_addr_t  s0_addr, s1_addr, s2_addr;
  axi_len_t   s0_len, s1_len, s2_len;
  axi_size_t  s0_size, s1_size, s2_size;
  axi_burst_t s0_burst, s1_burst, s2_burst;
  logic       s0_valid, s1_valid, s2_valid;
  logic       s0_ready, s1_ready, s2_ready;

  // Expected values from the data file and the forwarded request
  logic       exp_m0_ready;
  logic       exp_m1_ready;
  int         exp_slave;
  axi_ids_t   exp_id;
  axi_addr_t  fwd_addr;
  axi_len_t   fwd_len;
  axi_size_t  fwd_size;
  axi_burst_t fwd_burst;

  int test_num;
  int errors;
  int pass_count = 0;
  int fail_count = 0;
  int edge_count = 0;
  int lock_owner = -1;  // -1 while free
  int granted;
  bit aborted = 0;

  ar_crossbar uut (.*);

  initial clk = 1'b0;
  always #2 clk = ~clk;

  always @(posedge clk) edge_count <= edge_count + 1;

  // Polls from half-ns offsets so it never samples on an edge
  task automatic wait_clock_edge(output bit ok);
    int start;
    int steps;
    start = edge_count;
    steps = 0;
    while (edge_count == start && steps < EDGE_TIMEOUT) begin
      #1;
      steps++;
    end
    ok = (edge_count != start);
  endtask

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail test %0d: %s is %h, expected %h", test_num, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_slave_port(input int n, input axi_ids_t id, input axi_addr_t addr,
                                  input axi_len_t len, input axi_size_t size,
                                  input axi_burst_t burst, input logic valid);
    string p;
    bit    active;
    p = $sformatf("s%0d_", n);
    active = (exp_slave == n);
    compare_field({p, "valid"}, valid, active);
    compare_field({p, "id"}, id, active ? exp_id : '0);
    compare_field({p, "addr"}, addr, active ? fwd_addr : '0);
    compare_field({p, "len"}, len, active ? fwd_len : '0);
    compare_field({p, "size"}, size, active ? fwd_size : '0);
    compare_field({p, "burst"}, burst, active ? fwd_burst : '0);
  endtask

  // Granted master from the expected readies, else from the lock rule
  function automatic int pick_granted();
    if (exp_m0_ready) begin
      return 0;
    end
    if (exp_m1_ready) begin
      return 1;
    end
    if (lock_owner >= 0) begin
      return lock_owner;
    end
    if (m0_valid) begin
      return 0;
    end
    return m1_valid ? 1 : -1;
  endfunction

  task automatic update_lock_model();
    logic done;
    logic other_valid;
    done = (granted == 0) ? exp_m0_ready : (granted == 1) ? exp_m1_ready : 1'b0;
    other_valid = (granted == 0) ? m1_valid : m0_valid;
    if (lock_owner < 0) begin
      if (granted >= 0 && !done) begin
        lock_owner = granted;  // Stalled from free
      end
    end else if (done) begin
      lock_owner = other_valid ? 1 - granted : -1;
    end
  endtask

  initial begin
    bit ok;
    rstn = 1'b0;
    #0.5;
    wait_clock_edge(ok);
    wait_clock_edge(ok);
    #0.5;
    rstn = 1'b1;
  end

  initial begin
    string line;
    int    fd;
    int    count;
    int    steps;
    bit    ok;
    {m0_id, m0_addr, m0_len, m0_size, m0_burst, m0_valid} = '0;
    {m1_id, m1_addr, m1_len, m1_size, m1_burst, m1_valid} = '0;
    {s0_ready, s1_ready, s2_ready} = '0;
    fd = 0;
    steps = 0;
    #0.5;
    while (rstn !== 1'b1 && steps < RESET_TIMEOUT) begin
      #1;
      steps++;
    end
    if (rstn !== 1'b1) begin
      $display("Reset was not released within %0d ns", RESET_TIMEOUT);
      aborted = 1;
    end else begin
      wait_clock_edge(ok);
      #0.5;
      if (!ok) begin
        $display("Clock did not toggle after reset");
        aborted = 1;
      end
    end
    if (!aborted) begin
      fd = $fopen("verif/ar_testdata.txt", "r");
      if (fd == 0) begin
        $display("Cannot open the test data file verif/ar_testdata.txt");
        aborted = 1;
      end
    end
    while (!aborted && !$feof(fd)) begin
      line = "";
      count = $fgets(line, fd);
      if (count > 0 && line.getc(0) != "#") begin
        count = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        test_num, m0_id, m0_addr, m0_len, m0_size, m0_burst, m0_valid,
                        m1_id, m1_addr, m1_len, m1_size, m1_burst, m1_valid,
                        s0_ready, s1_ready, s2_ready,
                        exp_m0_ready, exp_m1_ready, exp_slave, exp_id);
        if (count == 20) begin
          errors = 0;
          granted = pick_granted();
          fwd_addr  = (granted == 1) ? m1_addr : m0_addr;
          fwd_len   = (granted == 1) ? m1_len : m0_len;
          fwd_size  = (granted == 1) ? m1_size : m0_size;
          fwd_burst = (granted == 1) ? m1_burst : m0_burst;
          #2;  // Sample 1 ns before the next edge
          compare_field("m0_ready", m0_ready, exp_m0_ready);
          compare_field("m1_ready", m1_ready, exp_m1_ready);
          check_slave_port(0, s0_id, s0_addr, s0_len, s0_size, s0_burst, s0_valid);
          check_slave_port(1, s1_id, s1_addr, s1_len, s1_size, s1_burst, s1_valid);
          check_slave_port(2, s2_id, s2_addr, s2_len, s2_size, s2_burst, s2_valid);
          if (errors == 0) begin
            pass_count++;
            $display("Test %0d ok", test_num);
          end else begin
            fail_count++;
            $display("Test %0d failed with %0d mismatches", test_num, errors);
          end
          update_lock_model();
          #0.5;
          wait_clock_edge(ok);
          #0.5;
          if (!ok) begin
            $display("Timed out waiting for a clock edge after test %0d", test_num);
            aborted = 1;
          end
        end else if (count > 0) begin
          $display("Malformed line in the test data file after test %0d", test_num);
          aborted = 1;
        end
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    $display("Summary: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0 && !aborted && pass_count > 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* verif/ar_testdata.txt */
# num | m0: id addr len size burst valid | m1: id addr len size burst valid | s0_rdy s1_rdy s2_rdy
# expected: m0_ready m1_ready slave (3 = none) slave_id; all hex except num
1  0 00000000 0 0 0 0  0 00000000 0 0 0 0  1 1 1  0 0 3 00
2  0 00000000 0 0 0 0  0 00000000 0 0 0 0  0 0 0  0 0 3 00
3  3 00001000 3 2 1 1  0 00000000 0 0 0 0  1 0 0  1 0 0 13
4  5 0000FFFF 0 2 1 1  0 00000000 0 0 0 0  1 0 0  1 0 0 15
5  7 00010000 7 3 1 1  0 00000000 0 0 0 0  0 1 0  1 0 1 17
6  A 0001FFFC F 2 2 1  0 00000000 0 0 0 0  0 1 0  1 0 1 1A
7  C 00020000 1 1 0 1  0 00000000 0 0 0 0  0 0 1  1 0 2 1C
8  F FFFFFFF0 2 0 1 1  0 00000000 0 0 0 0  0 0 1  1 0 2 1F
9  1 00000100 1 2 1 1  2 00010200 3 2 1 1  1 1 1  1 0 0 11
10 0 00000000 0 0 0 0  2 00010200 3 2 1 1  1 1 1  0 1 1 22
11 0 00000000 0 0 0 0  4 00000040 0 2 1 1  0 1 1  0 0 0 24
12 6 00010080 1 2 1 1  4 00000040 0 2 1 1  0 1 1  0 0 0 24
13 6 00010080 1 2 1 1  4 00000040 0 2 1 1  0 1 1  0 0 0 24
14 6 00010080 1 2 1 1  4 00000040 0 2 1 1  1 1 1  0 1 0 24
15 6 00010080 1 2 1 1  8 00020010 0 2 1 1  1 0 1  0 0 1 16
16 6 00010080 1 2 1 1  8 00020010 0 2 1 1  1 1 1  1 0 1 16
17 9 00000200 0 2 1 1  8 00020010 0 2 1 1  1 1 1  0 1 2 28
18 9 00000200 0 2 1 1  0 00000000 0 0 0 0  1 1 1  1 0 0 19
19 B 00010300 2 2 1 1  D 00000300 1 2 1 1  1 1 1  1 0 1 1B
20 0 00000000 0 0 0 0  D 00000300 1 2 1 1  1 1 1  0 1 0 2D
21 E 00020400 3 2 1 1  0 00000000 0 0 0 0  1 1 0  0 0 2 1E
22 E 00020400 3 2 1 1  3 00010500 1 2 1 1  1 1 0  0 0 2 1E
23 E 00020400 3 2 1 1  3 00010500 1 2 1 1  1 1 1  1 0 2 1E
24 0 00000000 0 0 0 0  3 00010500 1 2 1 1  1 1 1  0 1 1 23
25 4 00018000 2 2 1 1  0 00000000 0 0 0 0  1 0 1  0 0 1 14
26 4 00018000 2 2 1 1  0 00000000 0 0 0 0  0 0 0  0 0 1 14
27 4 00018000 2 2 1 1  0 00000000 0 0 0 0  1 0 0  0 0 1 14
28 4 00018000 2 2 1 1  0 00000000 0 0 0 0  0 1 0  1 0 1 14
29 0 00000000 0 0 0 0  0 00000000 0 0 0 0  1 1 1  0 0 3 00
30 5 00010010 0 2 1 1  0 00000000 0 0 0 0  1 1 0  1 0 1 15
31 0 00000000 0 0 0 0  0 00000000 0 0 0 0  0 0 0  0 0 3 00

/* files.f */
+incdir+verilog
verilog/axi_pkg.sv
verilog/ar_chan_if.sv
verilog/ar_arbiter.sv
verilog/ar_decoder.sv
verilog/ar_crossbar.sv
verif/ar_crossbar_tb.sv
